// ==== hdl/nnLayerPkg.sv ====
`default_nettype none

package nnLayerPkg;

	localparam int ActWidth = 8;
	localparam int WeightWidth = 8;
	localparam int AccWidth = 24;
	localparam int DefaultFracBits = 6;

	typedef logic signed [ActWidth-1:0] activation_t;
	typedef logic signed [WeightWidth-1:0] weight_t;
	typedef logic signed [AccWidth-1:0] acc_t;

	localparam int DefaultNumInputs = 10;
	localparam int DefaultNumNeurons = 4;

	// neuron n, input i at slice n*NumInputs+i; each row runs input 9 down to 0.
	localparam logic [DefaultNumNeurons*DefaultNumInputs*WeightWidth-1:0] DefaultWeights = {
		8'h15, 8'h9C, 8'h2A, 8'hF0, 8'h41, 8'hC8, 8'h07, 8'h33, 8'hE5, 8'h12, // neuron 3.
		8'h7B, 8'h05, 8'hA4, 8'h60, 8'hE9, 8'h11, 8'h57, 8'hD2, 8'h08, 8'h3E, // neuron 2.
		8'hD7, 8'h6E, 8'h3C, 8'h88, 8'h19, 8'hFA, 8'h44, 8'h0F, 8'hB6, 8'h21, // neuron 1.
		8'h64, 8'h18, 8'hD9, 8'h9F, 8'h6B, 8'h0A, 8'hBF, 8'h19, 8'h47, 8'hFC  // neuron 0.
	};

	// neuron 3 first.
	localparam logic [DefaultNumNeurons*WeightWidth-1:0] DefaultBiases = {
		8'h10,
		8'h03,
		8'hE8,
		8'hFA
	};

	// output side of the collector, one four-phase transfer per result.
	typedef enum logic [1:0] {
		idle,
		request,
		waitAckLow
	} collectState_t;

endpackage

`default_nettype wire

// ==== hdl/activationLoader.sv ====
`default_nettype none

module activationLoader #(
	parameter int NumInputs = nnLayerPkg::DefaultNumInputs,
	localparam int IdxWidth = (NumInputs > 1) ? $clog2(NumInputs) : 1
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic inReq,
	input wire nnLayerPkg::activation_t inData,
	input wire logic layerBusy,
	output logic inAck,
	output logic actStrobe,
	output nnLayerPkg::activation_t actData,
	output logic [IdxWidth-1:0] actIndex,
	output logic actLast
);

	localparam logic [IdxWidth-1:0] LastIdx = IdxWidth'(NumInputs - 1);

	logic [IdxWidth-1:0] inCount;
	logic acceptNow;

	// new request only once the previous ack has dropped.
	assign acceptNow = inReq && !inAck && !layerBusy;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inAck <= 1'b0;
			actStrobe <= 1'b0;
			inCount <= '0;
		end
		else
		begin
			actStrobe <= acceptNow; // rises together with inAck.
			if (acceptNow)
			begin
				inAck <= 1'b1;
				if (inCount == LastIdx)
					inCount <= '0;
				else
					inCount <= inCount + 1'b1;
			end
			else if (inAck && !inReq)
			begin
				inAck <= 1'b0; // source has released req.
			end
		end
	end

	// broadcast payload, held until the next accept.
	always_ff @(posedge clk)
	begin
		if (acceptNow)
		begin
			actData <= inData;
			actIndex <= inCount;
			actLast <= (inCount == LastIdx);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/neuronMac.sv ====
`default_nettype none

module neuronMac #(
	parameter int NumInputs = nnLayerPkg::DefaultNumInputs,
	parameter int FracBits = nnLayerPkg::DefaultFracBits,
	parameter logic [NumInputs*nnLayerPkg::WeightWidth-1:0] Weights = '0,
	parameter nnLayerPkg::weight_t Bias = '0,
	localparam int IdxWidth = (NumInputs > 1) ? $clog2(NumInputs) : 1
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic actStrobe,
	input wire nnLayerPkg::activation_t actData,
	input wire logic [IdxWidth-1:0] actIndex,
	input wire logic actLast,
	output logic resultValid,
	output nnLayerPkg::activation_t result
);

	import nnLayerPkg::*;

	localparam acc_t MaxOut = acc_t'((1 << (ActWidth - 1)) - 1);

	weight_t weight;
	acc_t product;
	acc_t accBase;
	acc_t acc;
	acc_t scaled;
	logic lastSeen;

	assign weight = weight_t'(Weights[actIndex*WeightWidth +: WeightWidth]);
	assign product = acc_t'(actData) * acc_t'(weight);

	// index 0 starts a new vector from the scaled bias.
	assign accBase = (actIndex == '0) ? (acc_t'(Bias) <<< FracBits) : acc;

	assign scaled = acc >>> FracBits;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
			lastSeen <= 1'b0;
			resultValid <= 1'b0;
		end
		else
		begin
			lastSeen <= actStrobe && actLast;
			resultValid <= lastSeen;
			if (actStrobe)
				acc <= accBase + product;
		end
	end

	// scale and clamp in the cycle after the last product.
	always_ff @(posedge clk)
	begin
		if (lastSeen)
		begin
			if (scaled < 0)
				result <= '0;
			else if (scaled > MaxOut)
				result <= activation_t'(MaxOut); // saturate.
			else
				result <= activation_t'(scaled);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/resultCollector.sv ====
`default_nettype none

module resultCollector #(
	parameter int NumNeurons = nnLayerPkg::DefaultNumNeurons,
	localparam int IdxWidth = (NumNeurons > 1) ? $clog2(NumNeurons) : 1
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic actLast,
	input wire logic actStrobe,
	input wire logic resultValid,
	input wire logic [NumNeurons*nnLayerPkg::ActWidth-1:0] results,
	input wire logic outAck,
	output logic layerBusy,
	output logic outReq,
	output nnLayerPkg::activation_t outData,
	output logic [IdxWidth-1:0] outIndex
);

	import nnLayerPkg::*;

	localparam logic [IdxWidth-1:0] LastIdx = IdxWidth'(NumNeurons - 1);

	collectState_t state;
	logic [NumNeurons*ActWidth-1:0] held;

	assign outData = activation_t'(held[outIndex*ActWidth +: ActWidth]);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			outReq <= 1'b0;
			outIndex <= '0;
			layerBusy <= 1'b0;
		end
		else
		begin
			if (actStrobe && actLast)
				layerBusy <= 1'b1; // input side stalls until drained.
			case (state)
				idle:
				begin
					if (resultValid)
					begin
						outIndex <= '0;
						outReq <= 1'b1;
						state <= request;
					end
				end
				request:
				begin
					if (outAck)
					begin
						outReq <= 1'b0;
						state <= waitAckLow;
					end
				end
				waitAckLow:
				begin
					if (!outAck)
					begin
						if (outIndex == LastIdx)
						begin
							layerBusy <= 1'b0;
							state <= idle;
						end
						else
						begin
							outIndex <= outIndex + 1'b1;
							outReq <= 1'b1;
							state <= request;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// one snapshot per vector.
	always_ff @(posedge clk)
	begin
		if (state == idle && resultValid)
			held <= results;
	end

endmodule

`default_nettype wire

// ==== hdl/denseLayer.sv ====
`default_nettype none

module denseLayer #(
	parameter int NumInputs = nnLayerPkg::DefaultNumInputs,
	parameter int NumNeurons = nnLayerPkg::DefaultNumNeurons,
	parameter int FracBits = nnLayerPkg::DefaultFracBits,
	parameter logic [NumNeurons*NumInputs*nnLayerPkg::WeightWidth-1:0] Weights =
		nnLayerPkg::DefaultWeights,
	parameter logic [NumNeurons*nnLayerPkg::WeightWidth-1:0] Biases = nnLayerPkg::DefaultBiases,
	localparam int OutIdxWidth = (NumNeurons > 1) ? $clog2(NumNeurons) : 1
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic inReq,
	input wire nnLayerPkg::activation_t inData,
	output logic inAck,
	output logic outReq,
	output nnLayerPkg::activation_t outData,
	output logic [OutIdxWidth-1:0] outIndex,
	input wire logic outAck
);

	import nnLayerPkg::*;

	localparam int InIdxWidth = (NumInputs > 1) ? $clog2(NumInputs) : 1;

	logic actStrobe;
	activation_t actData;
	logic [InIdxWidth-1:0] actIndex;
	logic actLast;
	logic layerBusy;
	logic [NumNeurons-1:0] resultValidVec;
	logic resultValid;
	logic [NumNeurons*ActWidth-1:0] results;

	activationLoader #(
		.NumInputs(NumInputs)
	) loader (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inData(inData),
		.layerBusy(layerBusy),
		.inAck(inAck),
		.actStrobe(actStrobe),
		.actData(actData),
		.actIndex(actIndex),
		.actLast(actLast)
	);

	for (genvar n = 0; n < NumNeurons; n++)
	begin : gNeuron
		neuronMac #(
			.NumInputs(NumInputs),
			.FracBits(FracBits),
			.Weights(Weights[n*NumInputs*WeightWidth +: NumInputs*WeightWidth]),
			.Bias(Biases[n*WeightWidth +: WeightWidth])
		) neuron (
			.clk(clk),
			.reset(reset),
			.actStrobe(actStrobe),
			.actData(actData),
			.actIndex(actIndex),
			.actLast(actLast),
			.resultValid(resultValidVec[n]),
			.result(results[n*ActWidth +: ActWidth])
		);
	end

	assign resultValid = &resultValidVec; // neurons run in lockstep.

	resultCollector #(
		.NumNeurons(NumNeurons)
	) collector (
		.clk(clk),
		.reset(reset),
		.actLast(actLast),
		.actStrobe(actStrobe),
		.resultValid(resultValid),
		.results(results),
		.outAck(outAck),
		.layerBusy(layerBusy),
		.outReq(outReq),
		.outData(outData),
		.outIndex(outIndex)
	);

endmodule

`default_nettype wire

// ==== sim/denseLayer_props.sv ====
`default_nettype none

module denseLayerProps (
	input wire logic clk,
	input wire logic reset,
	input wire logic inReq,
	input wire logic inAck,
	input wire logic outReq,
	input wire logic outAck,
	input wire nnLayerPkg::activation_t outData
);

	timeunit 1ns;
	timeprecision 1ps;

	// payload holds for the whole output request.
	assert property (@(posedge clk) disable iff (reset) outReq && $past(outReq) |-> $stable(outData))
		else $error("outData changed while outReq was high");

	assert property (@(posedge clk) disable iff (reset) $rose(inAck) |-> $past(inReq))
		else $error("inAck rose without inReq");

	// four-phase return to zero before the next result.
	assert property (@(posedge clk) disable iff (reset) $rose(outReq) |-> !$past(outAck))
		else $error("outReq rose again before outAck fell");

endmodule

bind denseLayer denseLayerProps props (
	.clk(clk),
	.reset(reset),
	.inReq(inReq),
	.inAck(inAck),
	.outReq(outReq),
	.outAck(outAck),
	.outData(outData)
);

`default_nettype wire

// ==== sim/denseLayerTb.sv ====
`default_nettype none

module denseLayerTb;

	timeunit 1ns;
	timeprecision 1ps;

	import nnLayerPkg::*;

	localparam int NumInputs = DefaultNumInputs;
	localparam int NumNeurons = DefaultNumNeurons;
	localparam int FracBits = DefaultFracBits;
	localparam int OutIdxWidth = (NumNeurons > 1) ? $clog2(NumNeurons) : 1;
	localparam activation_t ActMax = 8'sh7F;
	localparam activation_t ActMin = 8'sh80;

	localparam int RandomVectors = 40;
	localparam int SlowVectors = 6;
	localparam int TotalVectors = RandomVectors + 2 * NumNeurons + 2 + SlowVectors + 3;
	localparam int MaxSrcDelay = 3;
	localparam int MaxSlowDelay = 20;
	// four source phases per input, two slow sink phases per result.
	localparam int CyclesPerVector = NumInputs * 4 * (MaxSrcDelay + 4)
		+ NumNeurons * 2 * (MaxSlowDelay + 4) + 20;
	localparam longint TimeLimit = longint'(TotalVectors) * CyclesPerVector * 10 + 1000;

	logic clk = 1'b0;
	logic reset;
	logic inReq;
	activation_t inData;
	logic inAck;
	logic outReq;
	activation_t outData;
	logic [OutIdxWidth-1:0] outIndex;
	logic outAck;

	int errorCount = 0;
	int checkCount = 0;
	int sentCount = 0;
	int ackRises = 0;
	logic prevInAck = 1'b0;
	bit draining;
	logic lastSinkAck;
	activation_t vecQueue[$];
	int expQueue[$];

	always #5 clk = ~clk;

	denseLayer #(
		.NumInputs(NumInputs),
		.NumNeurons(NumNeurons),
		.FracBits(FracBits),
		.Weights(DefaultWeights),
		.Biases(DefaultBiases)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.outReq(outReq),
		.outData(outData),
		.outIndex(outIndex),
		.outAck(outAck)
	);

	always @(negedge clk)
	begin
		if (inAck && !prevInAck)
			ackRises <= ackRises + 1; // one per accepted activation.
		prevInAck <= inAck;
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("** Error: %s = 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
		end
	endtask

	task automatic printCounts();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
	endtask

	function automatic int weightAt(input int n, input int i);
		return int'(weight_t'(DefaultWeights[(n * NumInputs + i) * WeightWidth +: WeightWidth]));
	endfunction

	function automatic int biasAt(input int n);
		return int'(weight_t'(DefaultBiases[n * WeightWidth +: WeightWidth]));
	endfunction

	// scaled bias plus products, shifted back down and clamped to 0..127.
	function automatic int modelOutput(input int n, input activation_t acts[NumInputs]);
		int acc;
		acc = biasAt(n) * (1 << FracBits);
		for (int i = 0; i < NumInputs; i++)
			acc += int'(acts[i]) * weightAt(n, i);
		acc = acc >>> FracBits;
		if (acc < 0)
			return 0;
		if (acc > 127)
			return 127;
		return acc;
	endfunction

	task automatic pushVector(input activation_t acts[NumInputs]);
		for (int i = 0; i < NumInputs; i++)
			vecQueue.push_back(acts[i]);
		for (int n = 0; n < NumNeurons; n++)
			expQueue.push_back(modelOutput(n, acts));
	endtask

	task automatic sendInputs(input int count);
		repeat (count)
		begin
			repeat ($urandom_range(MaxSrcDelay, 0)) @(negedge clk);
			inData = vecQueue.pop_front();
			inReq = 1'b1;
			@(negedge clk);
			while (!inAck) @(negedge clk);
			repeat ($urandom_range(MaxSrcDelay, 0)) @(negedge clk);
			inReq = 1'b0;
			@(negedge clk);
			while (inAck) @(negedge clk);
			sentCount++;
		end
	endtask

	// one sink clock; no new input ack may start while results drain.
	task automatic sinkCycle();
		@(negedge clk);
		if (draining && inAck && !lastSinkAck)
		begin
			errorCount++;
			$display("inAck rose while results were still draining, at %0t ns", $time);
		end
		lastSinkAck = inAck;
	endtask

	task automatic receiveOutputs(input int count, input int minDelay, input int maxDelay);
		lastSinkAck = inAck;
		for (int k = 0; k < count; k++)
		begin
			while (!outReq) sinkCycle();
			if (k % NumNeurons == 0)
				draining = 1'b1;
			checkValue("outData", 32'(outData), 32'(expQueue.pop_front()));
			checkValue("outIndex", 32'(outIndex), 32'(k % NumNeurons));
			repeat ($urandom_range(maxDelay, minDelay)) sinkCycle();
			outAck = 1'b1;
			while (outReq) sinkCycle();
			repeat ($urandom_range(maxDelay, minDelay)) sinkCycle();
			outAck = 1'b0;
			if (k % NumNeurons == NumNeurons - 1)
				draining = 1'b0;
		end
	endtask

	task automatic runVectors(input int vectors, input int minDelay, input int maxDelay);
		fork
			sendInputs(vectors * NumInputs);
			receiveOutputs(vectors * NumNeurons, minDelay, maxDelay);
		join
	endtask

	initial
	begin
		activation_t acts[NumInputs];
		void'($urandom(32'he379_44ab));
		reset = 1'b1;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		draining = 1'b0;
		lastSinkAck = 1'b0;
		repeat (16) @(negedge clk);
		reset = 1'b0;

		for (int v = 0; v < RandomVectors; v++)
		begin
			for (int i = 0; i < NumInputs; i++)
				acts[i] = activation_t'($urandom);
			pushVector(acts);
		end
		runVectors(RandomVectors, 0, 3);

		// each neuron in turn driven far below zero, then far above 127.
		for (int n = 0; n < NumNeurons; n++)
		begin
			for (int i = 0; i < NumInputs; i++)
				acts[i] = (weightAt(n, i) < 0) ? ActMax : ActMin;
			pushVector(acts);
			expQueue[expQueue.size() - NumNeurons + n] = 0; // target neuron clamps low.
			for (int i = 0; i < NumInputs; i++)
				acts[i] = (weightAt(n, i) < 0) ? ActMin : ActMax;
			pushVector(acts);
			expQueue[expQueue.size() - NumNeurons + n] = 127; // target neuron saturates.
		end
		runVectors(2 * NumNeurons, 0, 3);

		for (int i = 0; i < NumInputs; i++)
			acts[i] = '0; // bias only.
		pushVector(acts);
		pushVector(acts);
		runVectors(2, 0, 3);

		for (int v = 0; v < SlowVectors; v++)
		begin
			for (int i = 0; i < NumInputs; i++)
				acts[i] = activation_t'($urandom);
			pushVector(acts);
		end
		runVectors(SlowVectors, 10, MaxSlowDelay);

		// half a vector, then reset.
		for (int i = 0; i < NumInputs / 2; i++)
			vecQueue.push_back(activation_t'($urandom));
		sendInputs(NumInputs / 2);
		reset = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		for (int v = 0; v < 2; v++)
		begin
			for (int i = 0; i < NumInputs; i++)
				acts[i] = activation_t'($urandom);
			pushVector(acts);
		end
		runVectors(2, 0, 3);

		checkValue("inAckRises", 32'(ackRises), 32'(sentCount));
		repeat (8) @(negedge clk);
		checkValue("outReq", 32'(outReq), 32'd0); // no result beyond the expected ones.
		printCounts();
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		#(TimeLimit);
		errorCount++;
		$display("timeout: the run did not finish within %0d ns", TimeLimit);
		printCounts();
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/nnLayerPkg.sv
hdl/activationLoader.sv
hdl/neuronMac.sv
hdl/resultCollector.sv
hdl/denseLayer.sv
sim/denseLayer_props.sv
sim/denseLayerTb.sv

// ==== Makefile ====
TOP = denseLayerTb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f build.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
